/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP = cpuTb
FILELIST = src.f
BUILD_DIR = obj_dir

.PHONY: sim clean

# The simulation binary exits with a failing status on $fatal
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* design/cpuPkg.sv */
`default_nettype none

package cpuPkg;

    // Datapath and instruction widths
    localparam int dataWidth = 64;
    localparam int instrWidth = 32;
    localparam int regAddrWidth = 5;

    // X31 always reads as zero
    localparam logic [regAddrWidth-1:0] zeroReg = 5'd31;

    // Instruction field positions
    localparam int rdLsb = 0;
    localparam int rnLsb = 5;
    localparam int rmLsb = 16;
    localparam int shamtLsb = 10;
    localparam int shamtWidth = 6;
    localparam int aluImmLsb = 10;
    localparam int aluImmWidth = 12;
    localparam int dtAddrLsb = 12;
    localparam int dtAddrWidth = 9;
    localparam int branchOffsetWidth = 26;
    localparam int formatLsb = 26;
    localparam int functionLsb = 21;
    localparam int iFunctionLsb = 22;

    // Format field, bits 31..26
    typedef enum logic [5:0] {
        rFormat = 6'b001010,
        iFormat = 6'b100010,
        dFormat = 6'b110100,
        bFormat = 6'b000011
    } instrFormatType;

    // R-format function, bits 25..21
    typedef enum logic [4:0] {
        ADD = 5'd0,
        AND = 5'd2,
        EOR = 5'd4,
        LSL = 5'd6,
        LSR = 5'd7,
        ORR = 5'd8,
        SUB = 5'd9
    } rFunctionType;

    // I-format function, bits 25..22
    typedef enum logic [3:0] {
        ADDI = 4'd0,
        ANDI = 4'd2,
        EORI = 4'd4,
        ORRI = 4'd6,
        SUBI = 4'd7
    } iFunctionType;

    // D-format function, bits 25..21
    typedef enum logic [4:0] {
        LDUR = 5'd0,
        STUR = 5'd1
    } dFunctionType;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOrr,
        aluEor,
        aluLsl,
        aluLsr
    } aluOpType;

endpackage

`default_nettype wire

/* design/cpuTop.sv */
`default_nettype none

module cpuTop #(
    parameter int dataWidth = cpuPkg::dataWidth
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [cpuPkg::instrWidth-1:0] ibus,
    output logic [dataWidth-1:0]          iaddrbus,
    output logic [dataWidth-1:0]          daddrbus,
    output logic [dataWidth-1:0]          dataOut,
    input  logic [dataWidth-1:0]          dataIn,
    output logic                          memWrite,
    output logic                          memRead
);

    logic [cpuPkg::instrWidth-1:0] instruction;
    logic [dataWidth-1:0] seqAddr;
    logic branchTaken;
    logic [dataWidth-1:0] branchOffset;

    // Decode stage outputs
    logic [cpuPkg::regAddrWidth-1:0] readAddrA;
    logic [cpuPkg::regAddrWidth-1:0] readAddrB;
    logic [cpuPkg::regAddrWidth-1:0] destAddr;
    cpuPkg::aluOpType aluOp;
    logic useImm;
    logic [dataWidth-1:0] immValue;
    logic decWriteEnable;
    logic loadOp;
    logic storeOp;
    logic [dataWidth-1:0] readDataA;
    logic [dataWidth-1:0] readDataB;

    // Memory and writeback
    logic [cpuPkg::regAddrWidth-1:0] resultDest;
    logic resultWriteEnable;
    logic writeEnable;
    logic [cpuPkg::regAddrWidth-1:0] writeAddr;
    logic [dataWidth-1:0] writeData;

    fetchUnit i_fetchUnit (
        .clk(clk),
        .reset(reset),
        .ibus(ibus),
        .branchTaken(branchTaken),
        .branchOffset(branchOffset),
        .iaddrbus(iaddrbus),
        .instruction(instruction),
        .seqAddr(seqAddr)
    );

    instrDecoder i_instrDecoder (
        .instruction(instruction),
        .readAddrA(readAddrA),
        .readAddrB(readAddrB),
        .destAddr(destAddr),
        .aluOp(aluOp),
        .useImm(useImm),
        .immValue(immValue),
        .writeEnable(decWriteEnable),
        .loadOp(loadOp),
        .storeOp(storeOp),
        .branchTaken(branchTaken),
        .branchOffset(branchOffset)
    );

    regFile i_regFile (
        .clk(clk),
        .reset(reset),
        .readAddrA(readAddrA),
        .readAddrB(readAddrB),
        .readDataA(readDataA),
        .readDataB(readDataB),
        .writeEnable(writeEnable),
        .writeAddr(writeAddr),
        .writeData(writeData)
    );

    executeStage #(
        .dataWidth(dataWidth)
    ) i_executeStage (
        .clk(clk),
        .reset(reset),
        .destAddr(destAddr),
        .aluOp(aluOp),
        .useImm(useImm),
        .immValue(immValue),
        .writeEnable(decWriteEnable),
        .loadOp(loadOp),
        .storeOp(storeOp),
        .readDataA(readDataA),
        .readDataB(readDataB),
        .daddrbus(daddrbus),
        .dataOut(dataOut),
        .memWrite(memWrite),
        .memRead(memRead),
        .resultDest(resultDest),
        .resultWriteEnable(resultWriteEnable)
    );

    memWriteback i_memWriteback (
        .clk(clk),
        .reset(reset),
        .aluResult(daddrbus),
        .dataIn(dataIn),
        .loadOp(memRead),
        .resultDest(resultDest),
        .resultWriteEnable(resultWriteEnable),
        .writeEnable(writeEnable),
        .writeAddr(writeAddr),
        .writeData(writeData)
    );

endmodule

`default_nettype wire

/* design/executeStage.sv */
`default_nettype none

module executeStage #(
    parameter int dataWidth = cpuPkg::dataWidth
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [cpuPkg::regAddrWidth-1:0] destAddr,
    input  cpuPkg::aluOpType                aluOp,
    input  logic                            useImm,
    input  logic [dataWidth-1:0]            immValue,
    input  logic                            writeEnable,
    input  logic                            loadOp,
    input  logic                            storeOp,
    input  logic [dataWidth-1:0]            readDataA,
    input  logic [dataWidth-1:0]            readDataB,
    output logic [dataWidth-1:0]            daddrbus,
    output logic [dataWidth-1:0]            dataOut,
    output logic                            memWrite,
    output logic                            memRead,
    output logic [cpuPkg::regAddrWidth-1:0] resultDest,
    output logic                            resultWriteEnable
);

    localparam int shiftWidth = $clog2(dataWidth);

    // ID/EX register contents
    logic [dataWidth-1:0] exA;
    logic [dataWidth-1:0] exB;
    logic [dataWidth-1:0] exImm;
    cpuPkg::aluOpType exOp;
    logic exUseImm;
    logic [cpuPkg::regAddrWidth-1:0] exDest;
    logic exWrite;
    logic exLoad;
    logic exStore;

    logic [dataWidth-1:0] operandB;
    logic [dataWidth-1:0] adderB;
    logic [dataWidth-1:0] adderSum;
    logic [dataWidth-1:0] aluResult;
    logic subtract;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            exWrite <= 1'b0;
            exLoad <= 1'b0;
            exStore <= 1'b0;
        end
        else
        begin
            exWrite <= writeEnable;
            exLoad <= loadOp;
            exStore <= storeOp;
        end
    end

    always_ff @(posedge clk)
    begin
        exA <= readDataA;
        exB <= readDataB;
        exImm <= immValue;
        exOp <= aluOp;
        exUseImm <= useImm;
        exDest <= destAddr;
    end

    assign operandB = exUseImm ? exImm : exB;

    // Subtract as a + ~b + 1
    assign subtract = (exOp == cpuPkg::aluSub);
    assign adderB = subtract ? ~operandB : operandB;

    lookaheadAdder #(
        .width(dataWidth)
    ) i_lookaheadAdder (
        .a(exA),
        .b(adderB),
        .carryIn(subtract),
        .sum(adderSum)
    );

    always_comb
    begin
        case (exOp)
            cpuPkg::aluAnd: aluResult = exA & operandB;
            cpuPkg::aluOrr: aluResult = exA | operandB;
            cpuPkg::aluEor: aluResult = exA ^ operandB;
            cpuPkg::aluLsl: aluResult = exA << operandB[shiftWidth-1:0];
            cpuPkg::aluLsr: aluResult = exA >> operandB[shiftWidth-1:0];
            default: aluResult = adderSum;
        endcase
    end

    // EX/MEM register drives the memory ports directly
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            memWrite <= 1'b0;
            memRead <= 1'b0;
            resultWriteEnable <= 1'b0;
        end
        else
        begin
            memWrite <= exStore;
            memRead <= exLoad;
            resultWriteEnable <= exWrite;
        end
    end

    always_ff @(posedge clk)
    begin
        daddrbus <= aluResult;
        dataOut <= exB;
        resultDest <= exDest;
    end

endmodule

`default_nettype wire

/* design/fetchUnit.sv */
`default_nettype none

module fetchUnit (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [cpuPkg::instrWidth-1:0]   ibus,
    input  logic                            branchTaken,
    input  logic [cpuPkg::dataWidth-1:0]    branchOffset,
    output logic [cpuPkg::dataWidth-1:0]    iaddrbus,
    output logic [cpuPkg::instrWidth-1:0]   instruction,
    output logic [cpuPkg::dataWidth-1:0]    seqAddr
);

    localparam logic [cpuPkg::dataWidth-1:0] wordBytes = 4;

    logic [cpuPkg::dataWidth-1:0] pcPlusFour;
    logic [cpuPkg::dataWidth-1:0] branchTarget;
    logic [cpuPkg::dataWidth-1:0] nextPc;

    assign pcPlusFour = iaddrbus + wordBytes;

    // Target is relative to the delay slot address held in IF/ID
    assign branchTarget = seqAddr + {branchOffset[cpuPkg::dataWidth-3:0], 2'b00};
    assign nextPc = branchTaken ? branchTarget : pcPlusFour;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            iaddrbus <= '0;
            // All-zero word has no valid format, so it decodes as a no-op
            instruction <= '0;
        end
        else
        begin
            iaddrbus <= nextPc;
            instruction <= ibus;
        end
    end

    always_ff @(posedge clk)
    begin
        seqAddr <= pcPlusFour;
    end

endmodule

`default_nettype wire

/* design/instrDecoder.sv */
`default_nettype none

module instrDecoder (
    input  logic [cpuPkg::instrWidth-1:0]   instruction,
    output logic [cpuPkg::regAddrWidth-1:0] readAddrA,
    output logic [cpuPkg::regAddrWidth-1:0] readAddrB,
    output logic [cpuPkg::regAddrWidth-1:0] destAddr,
    output cpuPkg::aluOpType                aluOp,
    output logic                            useImm,
    output logic [cpuPkg::dataWidth-1:0]    immValue,
    output logic                            writeEnable,
    output logic                            loadOp,
    output logic                            storeOp,
    output logic                            branchTaken,
    output logic [cpuPkg::dataWidth-1:0]    branchOffset
);

    localparam int dw = cpuPkg::dataWidth;

    logic [cpuPkg::regAddrWidth-1:0] rd;
    logic [cpuPkg::regAddrWidth-1:0] rm;
    logic [cpuPkg::shamtWidth-1:0] shamt;
    logic [cpuPkg::aluImmWidth-1:0] aluImm;
    logic [cpuPkg::dtAddrWidth-1:0] dtAddr;
    logic [cpuPkg::branchOffsetWidth-1:0] brOffset;
    logic [dw-1:0] aluImmExt;
    logic [dw-1:0] shamtExt;
    logic [dw-1:0] dtAddrExt;

    cpuPkg::instrFormatType format;
    cpuPkg::rFunctionType rFunc;
    cpuPkg::iFunctionType iFunc;
    cpuPkg::dFunctionType dFunc;

    assign rd = instruction[cpuPkg::rdLsb +: cpuPkg::regAddrWidth];
    assign rm = instruction[cpuPkg::rmLsb +: cpuPkg::regAddrWidth];
    assign shamt = instruction[cpuPkg::shamtLsb +: cpuPkg::shamtWidth];
    assign aluImm = instruction[cpuPkg::aluImmLsb +: cpuPkg::aluImmWidth];
    assign dtAddr = instruction[cpuPkg::dtAddrLsb +: cpuPkg::dtAddrWidth];
    assign brOffset = instruction[cpuPkg::branchOffsetWidth-1:0];

    assign format = cpuPkg::instrFormatType'(
        instruction[cpuPkg::formatLsb +: $bits(cpuPkg::instrFormatType)]);
    assign rFunc = cpuPkg::rFunctionType'(
        instruction[cpuPkg::functionLsb +: $bits(cpuPkg::rFunctionType)]);
    assign iFunc = cpuPkg::iFunctionType'(
        instruction[cpuPkg::iFunctionLsb +: $bits(cpuPkg::iFunctionType)]);
    assign dFunc = cpuPkg::dFunctionType'(
        instruction[cpuPkg::functionLsb +: $bits(cpuPkg::dFunctionType)]);

    // Immediate extensions
    assign aluImmExt = {{(dw - cpuPkg::aluImmWidth){aluImm[cpuPkg::aluImmWidth-1]}}, aluImm};
    assign shamtExt = {{(dw - cpuPkg::shamtWidth){1'b0}}, shamt};
    assign dtAddrExt = {{(dw - cpuPkg::dtAddrWidth){dtAddr[cpuPkg::dtAddrWidth-1]}}, dtAddr};
    assign branchOffset = {{(dw - cpuPkg::branchOffsetWidth){brOffset[cpuPkg::branchOffsetWidth-1]}},
        brOffset};

    assign readAddrA = instruction[cpuPkg::rnLsb +: cpuPkg::regAddrWidth];
    assign destAddr = rd;

    always_comb
    begin
        aluOp = cpuPkg::aluAdd;
        useImm = 1'b0;
        immValue = aluImmExt;
        writeEnable = 1'b0;
        loadOp = 1'b0;
        storeOp = 1'b0;
        branchTaken = 1'b0;
        readAddrB = rm;
        case (format)
            cpuPkg::rFormat:
            begin
                writeEnable = 1'b1;
                case (rFunc)
                    cpuPkg::ADD: aluOp = cpuPkg::aluAdd;
                    cpuPkg::SUB: aluOp = cpuPkg::aluSub;
                    cpuPkg::AND: aluOp = cpuPkg::aluAnd;
                    cpuPkg::ORR: aluOp = cpuPkg::aluOrr;
                    cpuPkg::EOR: aluOp = cpuPkg::aluEor;
                    cpuPkg::LSL, cpuPkg::LSR:
                    begin
                        // Shift amount comes from the shamt field
                        aluOp = (rFunc == cpuPkg::LSL) ? cpuPkg::aluLsl : cpuPkg::aluLsr;
                        useImm = 1'b1;
                        immValue = shamtExt;
                    end
                    default: writeEnable = 1'b0;
                endcase
            end
            cpuPkg::iFormat:
            begin
                writeEnable = 1'b1;
                useImm = 1'b1;
                case (iFunc)
                    cpuPkg::ADDI: aluOp = cpuPkg::aluAdd;
                    cpuPkg::SUBI: aluOp = cpuPkg::aluSub;
                    cpuPkg::ANDI: aluOp = cpuPkg::aluAnd;
                    cpuPkg::ORRI: aluOp = cpuPkg::aluOrr;
                    cpuPkg::EORI: aluOp = cpuPkg::aluEor;
                    default: writeEnable = 1'b0;
                endcase
            end
            cpuPkg::dFormat:
            begin
                useImm = 1'b1;
                immValue = dtAddrExt;
                case (dFunc)
                    cpuPkg::LDUR:
                    begin
                        loadOp = 1'b1;
                        writeEnable = 1'b1;
                    end
                    cpuPkg::STUR:
                    begin
                        // Store data register sits in the Rd field
                        storeOp = 1'b1;
                        readAddrB = rd;
                    end
                    default: ;
                endcase
            end
            cpuPkg::bFormat: branchTaken = 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* design/lookaheadAdder.sv */
`default_nettype none

module lookaheadAdder #(
    parameter int width = 64
) (
    input  logic [width-1:0] a,
    input  logic [width-1:0] b,
    input  logic             carryIn,
    output logic [width-1:0] sum
);

    // Binary tree in heap order: node 1 is the root, node width+i is bit i.
    // Group generate/propagate flow up, carries flow back down.
    for (genvar k = 1; k < 2 * width; k++)
    begin : node
        logic groupGen;
        logic groupProp;
        logic carry;

        if (k >= width)
        begin : leaf
            assign groupGen = a[k-width] & b[k-width];
            assign groupProp = a[k-width] ^ b[k-width];
            assign sum[k-width] = groupProp ^ carry;
        end
        else
        begin : group
            // Child 2k holds the lower half
            assign groupGen = node[2*k+1].groupGen | (node[2*k+1].groupProp & node[2*k].groupGen);
            assign groupProp = node[2*k+1].groupProp & node[2*k].groupProp;
        end

        if (k == 1)
            assign carry = carryIn;
        else if (k % 2 == 0)
            assign carry = node[k/2].carry;
        else
            assign carry = node[k-1].groupGen | (node[k-1].groupProp & node[k/2].carry);
    end

endmodule

`default_nettype wire

/* design/memWriteback.sv */
`default_nettype none

module memWriteback (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [cpuPkg::dataWidth-1:0]    aluResult,
    input  logic [cpuPkg::dataWidth-1:0]    dataIn,
    input  logic                            loadOp,
    input  logic [cpuPkg::regAddrWidth-1:0] resultDest,
    input  logic                            resultWriteEnable,
    output logic                            writeEnable,
    output logic [cpuPkg::regAddrWidth-1:0] writeAddr,
    output logic [cpuPkg::dataWidth-1:0]    writeData
);

    logic [cpuPkg::dataWidth-1:0] wbLoadData;
    logic [cpuPkg::dataWidth-1:0] wbAluData;
    logic wbSelectLoad;

    always_ff @(posedge clk)
    begin
        if (reset)
            writeEnable <= 1'b0;
        else
            writeEnable <= resultWriteEnable;
    end

    always_ff @(posedge clk)
    begin
        wbLoadData <= dataIn;
        wbAluData <= aluResult;
        wbSelectLoad <= loadOp;
        writeAddr <= resultDest;
    end

    assign writeData = wbSelectLoad ? wbLoadData : wbAluData;

endmodule

`default_nettype wire

/* design/regFile.sv */
`default_nettype none

module regFile (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [cpuPkg::regAddrWidth-1:0] readAddrA,
    input  logic [cpuPkg::regAddrWidth-1:0] readAddrB,
    output logic [cpuPkg::dataWidth-1:0]    readDataA,
    output logic [cpuPkg::dataWidth-1:0]    readDataB,
    input  logic                            writeEnable,
    input  logic [cpuPkg::regAddrWidth-1:0] writeAddr,
    input  logic [cpuPkg::dataWidth-1:0]    writeData
);

    logic [cpuPkg::dataWidth-1:0] regs [0:cpuPkg::zeroReg-1];

    // Zero register first, then write-through of a same-cycle write
    function automatic logic [cpuPkg::dataWidth-1:0] readPort(
        input logic [cpuPkg::regAddrWidth-1:0] addr
    );
        if (addr == cpuPkg::zeroReg)
            return '0;
        else if (writeEnable && addr == writeAddr)
            return writeData;
        else
            return regs[addr];
    endfunction

    assign readDataA = readPort(readAddrA);
    assign readDataB = readPort(readAddrB);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < int'(cpuPkg::zeroReg); i++)
                regs[i] <= '0;
        end
        else if (writeEnable && writeAddr != cpuPkg::zeroReg)
        begin
            regs[writeAddr] <= writeData;
        end
    end

endmodule

`default_nettype wire

/* src.f */
design/cpuPkg.sv
design/lookaheadAdder.sv
design/fetchUnit.sv
design/instrDecoder.sv
design/regFile.sv
design/executeStage.sv
design/memWriteback.sv
design/cpuTop.sv
test/cpuTb.sv

/* test/cpuTb.sv */
`default_nettype none

module cpuTb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int noAccess = 0;
    localparam int loadAccess = 1;
    localparam int storeAccess = 2;
    localparam int cycleLimit = 400;
    localparam int lastSlot = 62;

    // Format and function encodings
    localparam logic [5:0] rFmt = 6'b001010;
    localparam logic [5:0] iFmt = 6'b100010;
    localparam logic [5:0] dFmt = 6'b110100;
    localparam logic [5:0] bFmt = 6'b000011;
    localparam logic [4:0] fnAdd = 5'd0;
    localparam logic [4:0] fnAnd = 5'd2;
    localparam logic [4:0] fnEor = 5'd4;
    localparam logic [4:0] fnLsl = 5'd6;
    localparam logic [4:0] fnLsr = 5'd7;
    localparam logic [4:0] fnOrr = 5'd8;
    localparam logic [4:0] fnSub = 5'd9;
    localparam logic [3:0] fnAddi = 4'd0;
    localparam logic [3:0] fnAndi = 4'd2;
    localparam logic [3:0] fnEori = 4'd4;
    localparam logic [3:0] fnOrri = 4'd6;
    localparam logic [3:0] fnSubi = 4'd7;
    localparam logic [4:0] fnLdur = 5'd0;
    localparam logic [4:0] fnStur = 5'd1;

    logic clk;
    logic reset;
    logic [31:0] ibus;
    logic [63:0] iaddrbus;
    logic [63:0] daddrbus;
    logic [63:0] dataOut;
    logic [63:0] dataIn;
    logic memWrite;
    logic memRead;

    logic [31:0] imem [0:255];
    logic [63:0] dmem [0:255];
    logic [63:0] refMem [0:255];
    logic [63:0] regModel [0:31];

    // Expected accesses, entry 2 is in the memory stage this cycle
    int pipeKind [0:2];
    logic [63:0] pipeAddr [0:2];
    logic [63:0] pipeData [0:2];

    logic [63:0] expPc;
    logic branchArmed;
    logic [63:0] branchTarget;
    int seed;

    cpuTop i_cpuTop (
        .clk(clk),
        .reset(reset),
        .ibus(ibus),
        .iaddrbus(iaddrbus),
        .daddrbus(daddrbus),
        .dataOut(dataOut),
        .dataIn(dataIn),
        .memWrite(memWrite),
        .memRead(memRead)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] aluR(input logic [4:0] func, input int rd, input int rn,
        input int rm);
        return {rFmt, func, rm[4:0], 6'd0, rn[4:0], rd[4:0]};
    endfunction

    function automatic logic [31:0] shiftR(input logic [4:0] func, input int rd, input int rn,
        input int shamt);
        return {rFmt, func, 5'd0, shamt[5:0], rn[4:0], rd[4:0]};
    endfunction

    function automatic logic [31:0] aluI(input logic [3:0] func, input int rd, input int rn,
        input int imm);
        return {iFmt, func, imm[11:0], rn[4:0], rd[4:0]};
    endfunction

    function automatic logic [31:0] memD(input logic [4:0] func, input int rt, input int rn,
        input int offset);
        return {dFmt, func, offset[8:0], 2'b00, rn[4:0], rt[4:0]};
    endfunction

    function automatic logic [31:0] branchB(input int offset);
        return {bFmt, offset[25:0]};
    endfunction

    // Unused format code, low bits follow the word index
    function automatic logic [31:0] nopWord(input int index);
        return {6'b111111, index[25:0]};
    endfunction

    function automatic logic [63:0] modelRead(input logic [4:0] idx);
        if (idx == 5'd31)
            return 64'd0;
        return regModel[idx];
    endfunction

    task automatic modelWrite(input logic [4:0] idx, input logic [63:0] value);
        if (idx != 5'd31)
            regModel[idx] = value;
    endtask

    task automatic failRun();
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped on the first failure");
    endtask

    task automatic checkValue(input string name, input logic [63:0] actual,
        input logic [63:0] expected);
        assert (actual === expected)
        else
        begin
            $display("Error at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
            failRun();
        end
    endtask

    // Applies one fetched word to the reference state in program order
    task automatic modelExecute(input logic [31:0] word, input logic [63:0] pc);
        logic [4:0] rd;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] imm;
        logic [63:0] addr;
        rd = word[4:0];
        a = modelRead(word[9:5]);
        b = modelRead(word[20:16]);
        imm = {{52{word[21]}}, word[21:10]};
        addr = a + {{55{word[20]}}, word[20:12]};
        pipeKind[0] = noAccess;
        case (word[31:26])
            rFmt:
                case (word[25:21])
                    fnAdd: modelWrite(rd, a + b);
                    fnSub: modelWrite(rd, a - b);
                    fnAnd: modelWrite(rd, a & b);
                    fnOrr: modelWrite(rd, a | b);
                    fnEor: modelWrite(rd, a ^ b);
                    fnLsl: modelWrite(rd, a << word[15:10]);
                    fnLsr: modelWrite(rd, a >> word[15:10]);
                    default: ;
                endcase
            iFmt:
                case (word[25:22])
                    fnAddi: modelWrite(rd, a + imm);
                    fnSubi: modelWrite(rd, a - imm);
                    fnAndi: modelWrite(rd, a & imm);
                    fnOrri: modelWrite(rd, a | imm);
                    fnEori: modelWrite(rd, a ^ imm);
                    default: ;
                endcase
            dFmt:
            begin
                if (word[25:21] == fnLdur)
                begin
                    modelWrite(rd, refMem[addr[10:3]]);
                    pipeKind[0] = loadAccess;
                    pipeAddr[0] = addr;
                end
                else if (word[25:21] == fnStur)
                begin
                    // Store data comes from the Rd field
                    pipeKind[0] = storeAccess;
                    pipeAddr[0] = addr;
                    pipeData[0] = modelRead(rd);
                    refMem[addr[10:3]] = modelRead(rd);
                end
            end
            bFmt:
            begin
                branchArmed = 1'b1;
                branchTarget = pc + 64'd4 + {{36{word[25]}}, word[25:0], 2'b00};
            end
            default: ;
        endcase
    endtask

    // Checks the outputs of this cycle, then drives the next fetch and load data
    task automatic runCycle();
        logic [31:0] word;
        logic [63:0] nextPc;
        checkValue("iaddrbus", iaddrbus, expPc);
        checkValue("memWrite", {63'd0, memWrite}, {63'd0, pipeKind[2] == storeAccess});
        checkValue("memRead", {63'd0, memRead}, {63'd0, pipeKind[2] == loadAccess});
        if (memWrite)
        begin
            checkValue("daddrbus", daddrbus, pipeAddr[2]);
            checkValue("dataOut", dataOut, pipeData[2]);
            dmem[daddrbus[10:3]] = dataOut;
        end
        if (memRead)
        begin
            checkValue("daddrbus", daddrbus, pipeAddr[2]);
            dataIn = dmem[daddrbus[10:3]];
        end
        for (int i = 2; i > 0; i--)
        begin
            pipeKind[i] = pipeKind[i-1];
            pipeAddr[i] = pipeAddr[i-1];
            pipeData[i] = pipeData[i-1];
        end
        word = imem[expPc[9:2]];
        ibus = word;
        // A branch fetched last cycle redirects the fetch after its delay slot
        if (branchArmed)
        begin
            nextPc = branchTarget;
            branchArmed = 1'b0;
        end
        else
        begin
            nextPc = expPc + 64'd4;
        end
        modelExecute(word, expPc);
        expPc = nextPc;
    endtask

    // Dependent instructions sit at least three fetch slots after their producer
    task automatic loadProgram();
        imem[0] = aluI(fnAddi, 1, 31, 256);
        imem[1] = aluI(fnAddi, 2, 31, -1);
        imem[2] = aluI(fnAddi, 3, 31, 1);
        imem[3] = aluI(fnOrri, 4, 31, 'h5a3);
        imem[4] = memD(fnStur, 2, 1, 0);
        imem[5] = aluR(fnSub, 5, 31, 3);
        imem[6] = aluR(fnAdd, 6, 2, 3);
        imem[7] = aluI(fnEori, 7, 4, 'h0ff);
        imem[8] = memD(fnStur, 5, 1, 8);
        imem[9] = memD(fnStur, 6, 1, 16);
        imem[10] = memD(fnStur, 7, 1, 24);
        imem[11] = aluI(fnAndi, 8, 2, 'h8f0);
        imem[12] = aluR(fnAnd, 9, 2, 4);
        imem[13] = aluR(fnOrr, 10, 4, 3);
        imem[14] = memD(fnStur, 8, 1, 32);
        imem[15] = memD(fnStur, 9, 1, 40);
        imem[16] = memD(fnStur, 10, 1, 48);
        imem[17] = aluR(fnEor, 11, 2, 4);
        imem[18] = aluI(fnSubi, 12, 3, 2);
        // Writes aimed at X31 are dropped
        imem[19] = aluI(fnAddi, 31, 3, 5);
        imem[20] = memD(fnStur, 11, 1, 56);
        imem[21] = memD(fnStur, 12, 1, 64);
        imem[22] = memD(fnStur, 31, 1, 72);
        imem[23] = aluR(fnAdd, 31, 2, 2);
        imem[24] = shiftR(fnLsl, 13, 4, 0);
        imem[25] = shiftR(fnLsl, 14, 4, 1);
        imem[26] = aluR(fnAdd, 15, 31, 2);
        imem[27] = memD(fnStur, 13, 1, 80);
        imem[28] = memD(fnStur, 14, 1, 88);
        imem[29] = memD(fnStur, 15, 1, 96);
        imem[30] = shiftR(fnLsl, 16, 3, 63);
        imem[31] = shiftR(fnLsr, 17, 2, 63);
        imem[32] = shiftR(fnLsr, 18, 2, 1);
        imem[33] = memD(fnStur, 16, 1, 104);
        imem[34] = memD(fnStur, 17, 1, 112);
        imem[35] = memD(fnStur, 18, 1, 120);
        imem[36] = shiftR(fnLsr, 19, 4, 0);
        imem[37] = memD(fnLdur, 20, 31, 8);
        imem[38] = memD(fnLdur, 21, 1, -8);
        imem[39] = memD(fnStur, 19, 1, 128);
        imem[40] = memD(fnStur, 20, 1, 136);
        imem[41] = memD(fnStur, 21, 1, 144);
        imem[42] = branchB(4);
        imem[43] = memD(fnStur, 3, 1, 152);
        // Skipped by the branch at slot 42
        imem[44] = memD(fnStur, 2, 1, 160);
        imem[47] = branchB(6);
        imem[48] = aluI(fnAddi, 22, 31, 'h123);
        imem[51] = memD(fnStur, 22, 1, 168);
        imem[52] = branchB(7);
        imem[53] = aluI(fnAddi, 23, 31, 77);
        imem[54] = aluI(fnAddi, 24, 31, -100);
        imem[55] = branchB(-5);
        imem[56] = aluI(fnOrri, 25, 31, 'h0f0);
        imem[60] = memD(fnStur, 24, 1, 176);
        imem[61] = memD(fnStur, 25, 1, 184);
        imem[62] = memD(fnStur, 23, 1, 192);
    endtask

    initial
    begin
        int cycles;
        int drain;
        reset = 1'b1;
        ibus = '0;
        dataIn = '0;
        seed = 34;
        expPc = '0;
        branchArmed = 1'b0;
        branchTarget = '0;
        for (int i = 0; i < 256; i++)
        begin
            imem[i] = nopWord(i);
            dmem[i] = {$random(seed), $random(seed)};
            refMem[i] = dmem[i];
        end
        for (int i = 0; i < 32; i++)
            regModel[i] = '0;
        for (int i = 0; i < 3; i++)
        begin
            pipeKind[i] = noAccess;
            pipeAddr[i] = '0;
            pipeData[i] = '0;
        end
        loadProgram();

        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        cycles = 0;
        drain = 0;
        // Run past the last slot until its store has left the memory stage
        while (drain < 5)
        begin
            runCycle();
            if (expPc > 64'(lastSlot * 4) && !branchArmed)
                drain++;
            cycles++;
            if (cycles > cycleLimit)
            begin
                $display("Timeout: the program did not finish within %0d cycles", cycleLimit);
                failRun();
            end
            @(negedge clk);
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire
